// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/inst_decoder.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/pc_unit.sv
  - hdl/mem_wb_unit.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - dv/rv_core_assert.sv
      - dv/rv_core_tb.sv

// ==== dv/rv_core_assert.sv ====
`timescale 1ns/100ps

module rv_core_assert (
  input logic        i_clk,
  input logic        i_reset,
  input logic [4:0]  i_rs1,
  input logic [4:0]  i_rs2,
  input logic [31:0] i_rs1_data,
  input logic [31:0] i_rs2_data,
  input logic        i_mem_we,
  input logic        i_mem_re,
  input logic [3:0]  i_mem_be
);

  int fail_count = 0; // Number of failed assertions

  x0_rs1_zero: assert property (@(posedge i_clk) (i_rs1 == 5'd0) |-> (i_rs1_data == '0))
    else begin fail_count++; $error("rs1 read of x0 returned non-zero data"); end

  x0_rs2_zero: assert property (@(posedge i_clk) (i_rs2 == 5'd0) |-> (i_rs2_data == '0))
    else begin fail_count++; $error("rs2 read of x0 returned non-zero data"); end

  store_has_lanes: assert property (@(posedge i_clk) i_mem_we |-> (i_mem_be != 4'b0000))
    else begin fail_count++; $error("store strobe with empty byte enable"); end

  strobes_exclusive: assert property (@(posedge i_clk) !(i_mem_we && i_mem_re))
    else begin fail_count++; $error("load and store strobes set together"); end

  // Memory port quiet while in reset
  reset_quiet: assert property (@(posedge i_clk) i_reset |-> (!i_mem_we && !i_mem_re))
    else begin fail_count++; $error("memory strobe active during reset"); end

endmodule

// Register file read ports come from the core's internal nets
bind rv_core rv_core_assert core_assert_i (
  .i_clk      (i_clk),
  .i_reset    (i_reset),
  .i_rs1      (rs1),
  .i_rs2      (rs2),
  .i_rs1_data (rs1_data),
  .i_rs2_data (rs2_data),
  .i_mem_we   (o_mem_we),
  .i_mem_re   (o_mem_re),
  .i_mem_be   (o_mem_be)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  localparam int N_INST         = 2000;
  localparam int TIMEOUT_CYCLES = N_INST + N_INST / 20; // Run length plus 5% margin
  localparam int MEM_WORDS      = 256;

  logic        i_clk;
  logic        i_reset;
  logic [31:0] i_inst;
  logic [31:0] mem_rdata;
  logic [31:0] o_pc, o_mem_addr, o_mem_wdata;
  logic [3:0]  o_mem_be;
  logic        o_mem_we, o_mem_re;

  logic [31:0] lfsr;
  logic [31:0] data_mem [MEM_WORDS]; // Memory seen by the DUT
  logic [31:0] ref_mem  [MEM_WORDS]; // Model copy
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  logic        st_we;                // Store sampled from the port
  logic [7:0]  st_idx;
  logic [31:0] st_word;
  int          cycles;

  rv_core dut_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_inst      (i_inst),
    .i_mem_rdata (mem_rdata),
    .o_pc        (o_pc),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_mem_be    (o_mem_be),
    .o_mem_we    (o_mem_we),
    .o_mem_re    (o_mem_re)
  );

  assign mem_rdata = data_mem[o_mem_addr[9:2]]; // Same-cycle read

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge i_clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $fatal(1, "Run stopped by timeout");
      end
    end
  end

  // Bound assertions on the core end the run at their first failure
  always @(dut_i.core_assert_i.fail_count) begin
    if (dut_i.core_assert_i.fail_count != 0) begin
      $display("A concurrent assertion on the core failed at %0t", $time);
      $display("Verification failed");
      $fatal(1, "Assertion failure during the run");
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) w[8*k +: 8] = data[8*k +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] bits;
    logic [31:0] pick;
    logic [4:0]  opc;
    logic [31:0] inst;
    bits = rand_bits(32);
    pick = rand_bits(4);
    case (pick[3:0])
      4'd0:         opc = OP_LUI;
      4'd1:         opc = OP_AUIPC;
      4'd2:         opc = OP_JAL;
      4'd3:         opc = OP_JALR;
      4'd4, 4'd5:   opc = OP_BRANCH;
      4'd6, 4'd7:   opc = OP_LOAD;
      4'd8, 4'd9:   opc = OP_STORE;
      4'd10, 4'd11: opc = OP_IMM;
      4'd12, 4'd13: opc = OP_REG;
      4'd14:        opc = bits[2] ? OP_SYSTEM : OP_MISC_MEM;
      default:      opc = {bits[4:3], 3'b010}; // Opcodes outside the subset
    endcase
    inst = {bits[31:7], opc, 2'b11};
    case (opc)
      OP_JALR: inst[14:12] = 3'b000;
      OP_BRANCH: begin
        if (inst[14:13] == 2'b01) inst[14] = 1'b1; // No branch with funct3 010/011
        if (rand_bits(1) == 32'd1) inst[24:20] = inst[19:15]; // Equal operands
      end
      OP_LOAD: begin
        if (inst[14:12] inside {3'b011, 3'b110, 3'b111}) inst[14:12] = 3'b010;
      end
      OP_STORE: begin
        inst[14] = 1'b0;
        if (inst[13:12] == 2'b11) inst[12] = 1'b0;
      end
      OP_IMM: begin
        if (inst[13:12] == 2'b01) inst[31:25] = {1'b0, inst[14] & inst[30], 5'b0};
      end
      OP_REG: begin
        inst[31:25] = {1'b0, (inst[13:12] == 2'b01 || inst[13:12] == 2'b00) & inst[30], 5'b0};
        if (inst[14:12] == 3'b001) inst[30] = 1'b0;
      end
      default: ;
    endcase
    return inst;
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000: return alt ? x - y : x + y;
      3'b001: return x << y[4:0];
      3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011: return (x < y) ? 32'd1 : 32'd0;
      3'b100: return x ^ y;
      3'b101: begin
        if (alt) return $signed(x) >>> y[4:0]; // Sign bit shifted in
        return x >> y[4:0];
      end
      3'b110: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [1:0] off,
                                             input logic [31:0] word);
    logic [7:0]  bt;
    logic [15:0] hw;
    bt = word[8*off +: 8];
    hw = off[1] ? word[31:16] : word[15:0]; // Bit 0 ignored for halves
    case (f3)
      3'b000:  return {{24{bt[7]}}, bt};
      3'b001:  return {{16{hw[15]}}, hw};
      3'b100:  return {24'b0, bt};
      3'b101:  return {16'b0, hw};
      default: return word;
    endcase
  endfunction

  // Compares the port with the ISA model, then retires the instruction in the model
  task automatic check_and_step(input logic [31:0] inst);
    logic [4:0]  op, rd;
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] addr, res, next_pc, lanes, mask;
    logic [3:0]  be;
    logic        wr;
    op      = inst[6:2];
    rd      = inst[11:7];
    f3      = inst[14:12];
    a       = ref_regs[inst[19:15]];
    b       = ref_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u   = {inst[31:12], 12'b0};
    imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    addr    = a + ((op == OP_STORE) ? imm_s : imm_i);
    next_pc = ref_pc + 32'd4;
    res     = '0;
    wr      = 1'b1;
    check_value(o_pc, ref_pc, "PC");
    if (op != OP_STORE) check_value({31'b0, o_mem_we}, 32'd0, "store strobe");
    if (op != OP_LOAD)  check_value({31'b0, o_mem_re}, 32'd0, "load strobe");
    case (op)
      OP_LUI:   res = imm_u;
      OP_AUIPC: res = ref_pc + imm_u;
      OP_JAL: begin
        res     = ref_pc + 32'd4;
        next_pc = ref_pc + imm_j;
      end
      OP_JALR: begin
        res     = ref_pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        wr = 1'b0;
        if (branch_taken(f3, a, b)) next_pc = ref_pc + imm_b;
      end
      OP_LOAD: begin
        check_value({31'b0, o_mem_re}, 32'd1, "load strobe");
        check_value(o_mem_addr, addr, "load address");
        res = load_value(f3, addr[1:0], ref_mem[addr[9:2]]);
      end
      OP_STORE: begin
        wr = 1'b0;
        case (f3[1:0])
          2'b00: begin
            be    = 4'b0001 << addr[1:0];
            lanes = {24'b0, b[7:0]} << (8 * addr[1:0]);
          end
          2'b01: begin
            be    = addr[1] ? 4'b1100 : 4'b0011;
            lanes = addr[1] ? {b[15:0], 16'b0} : {16'b0, b[15:0]};
          end
          default: begin
            be    = 4'b1111;
            lanes = b;
          end
        endcase
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        check_value({31'b0, o_mem_we}, 32'd1, "store strobe");
        check_value(o_mem_addr, addr, "store address");
        check_value({28'b0, o_mem_be}, {28'b0, be}, "byte enable");
        check_value(o_mem_wdata & mask, lanes & mask, "store data lanes");
        ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], lanes, be);
      end
      OP_IMM: res = alu_model(f3, (f3 == 3'b101) && inst[30], a, imm_i);
      OP_REG: res = alu_model(f3, inst[30], a, b);
      default: wr = 1'b0; // FENCE, SYSTEM and unknown opcodes
    endcase
    if (wr && rd != 5'd0) ref_regs[rd] = res;
    ref_pc = next_pc;
  endtask

  task automatic check_last_store();
    if (st_we) check_value(data_mem[st_idx], ref_mem[st_idx], "memory word after store");
  endtask

  initial begin
    logic [31:0] next_inst;
    lfsr    = 32'hee53_eabe;
    i_reset = 1'b1;
    i_inst  = 32'h0000_2023; // SW x0, 0(x0) to exercise strobes in reset
    st_we   = 1'b0;
    st_idx  = '0;
    st_word = '0;
    ref_pc  = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      data_mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'd17, 8'hc3 ^ i[7:0]};
      ref_mem[i]  = data_mem[i];
    end
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset <= 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      next_inst = random_inst();
      i_inst <= next_inst;
      @(negedge i_clk);
      check_last_store();
      check_and_step(next_inst);
      st_we   = o_mem_we;
      st_idx  = o_mem_addr[9:2];
      st_word = merge_bytes(data_mem[o_mem_addr[9:2]], o_mem_wdata, o_mem_be);
      @(posedge i_clk);
      if (st_we) data_mem[st_idx] <= st_word;
    end
    @(negedge i_clk);
    check_last_store();
    check_value(o_pc, ref_pc, "PC after last instruction");
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  rv_pkg::alu_op_e         i_op,
  input  logic [rv_pkg::XLEN-1:0] i_a,       // rs1 data
  input  logic [rv_pkg::XLEN-1:0] i_b,       // rs2 data
  input  logic                    i_src_pc,  // Operand a from PC
  input  logic                    i_src_imm, // Operand b from immediate
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  output logic [rv_pkg::XLEN-1:0] o_result
);
  import rv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = i_src_pc ? i_pc : i_a;
  assign op_b  = i_src_imm ? i_imm : i_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_op)
      ADD:     o_result = op_a + op_b;
      SUB:     o_result = op_a - op_b;
      SLL:     o_result = op_a << shamt;
      SLT:     o_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU:    o_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      XOR:     o_result = op_a ^ op_b;
      SRL:     o_result = op_a >> shamt;
      SRA:     o_result = $signed(op_a) >>> shamt; // Arithmetic keeps sign
      OR:      o_result = op_a | op_b;
      AND:     o_result = op_a & op_b;
      default: o_result = op_a + op_b;
    endcase
  end

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
  input  logic [31:0]               i_inst,
  output logic [rv_pkg::REG_AW-1:0] o_rs1,
  output logic [rv_pkg::REG_AW-1:0] o_rs2,
  output logic [rv_pkg::REG_AW-1:0] o_rd,
  output logic [rv_pkg::XLEN-1:0]   o_imm,
  output rv_pkg::alu_op_e           o_alu_op,
  output logic                      o_alu_src_imm,
  output logic                      o_alu_src_pc,
  output logic                      o_reg_write,
  output logic                      o_branch,
  output logic                      o_jal,
  output logic                      o_jalr,
  output logic                      o_mem_read,
  output logic                      o_mem_write,
  output logic [2:0]                o_funct3,
  output rv_pkg::wb_sel_e           o_wb_sel
);
  import rv_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            alt;       // Bit 30 selects SUB / SRA
  logic            is_shift;  // Immediate shift forms
  logic            reg_we;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode   = opcode_e'(i_inst[6:2]);
  assign funct3   = i_inst[14:12];
  assign alt      = i_inst[30];
  assign is_shift = (funct3[1:0] == 2'b01);

  assign o_rd     = i_inst[11:7];
  assign o_rs1    = i_inst[19:15];
  assign o_rs2    = i_inst[24:20];
  assign o_funct3 = funct3;

  // Sign-extended immediates per format
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic sel_alt);
    case (f3)
      3'b000:  return sel_alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return sel_alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  always_comb begin
    o_imm         = '0;
    o_alu_op      = ADD;
    o_alu_src_imm = 1'b0;
    o_alu_src_pc  = 1'b0;
    reg_we        = 1'b0;
    o_branch      = 1'b0;
    o_jal         = 1'b0;
    o_jalr        = 1'b0;
    o_mem_read    = 1'b0;
    o_mem_write   = 1'b0;
    o_wb_sel      = WB_ALU;
    case (opcode)
      OP_LUI: begin
        o_imm    = imm_u;
        reg_we   = 1'b1;
        o_wb_sel = WB_IMM;
      end
      OP_AUIPC: begin
        o_imm         = imm_u;
        o_alu_src_pc  = 1'b1; // PC + imm through the adder
        o_alu_src_imm = 1'b1;
        reg_we        = 1'b1;
      end
      OP_JAL: begin
        o_imm    = imm_j;
        o_jal    = 1'b1;
        reg_we   = 1'b1;
        o_wb_sel = WB_PC4;
      end
      OP_JALR: begin
        o_imm         = imm_i;
        o_alu_src_imm = 1'b1; // Target base from rs1 + imm
        o_jalr        = 1'b1;
        reg_we        = 1'b1;
        o_wb_sel      = WB_PC4;
      end
      OP_BRANCH: begin
        o_imm    = imm_b;
        o_branch = 1'b1;
      end
      OP_LOAD: begin
        o_imm         = imm_i;
        o_alu_src_imm = 1'b1;
        o_mem_read    = 1'b1;
        reg_we        = 1'b1;
        o_wb_sel      = WB_LOAD;
      end
      OP_STORE: begin
        o_imm         = imm_s;
        o_alu_src_imm = 1'b1;
        o_mem_write   = 1'b1;
      end
      OP_IMM: begin
        // Shifts carry a 5-bit shamt and bit 30 only matters for SRAI
        o_imm         = is_shift ? {27'b0, i_inst[24:20]} : imm_i;
        o_alu_src_imm = 1'b1;
        o_alu_op      = alu_op_of(funct3, is_shift && alt);
        reg_we        = 1'b1;
      end
      OP_REG: begin
        o_alu_op = alu_op_of(funct3, alt);
        reg_we   = 1'b1;
      end
      OP_MISC_MEM, OP_SYSTEM: ; // Retire as no-ops
      default: ;
    endcase
  end

  assign o_reg_write = reg_we && (o_rd != '0); // x0 never written

endmodule

// ==== hdl/mem_wb_unit.sv ====
`timescale 1ns/100ps

module mem_wb_unit (
  input  logic                    i_reset,
  input  logic                    i_mem_read,
  input  logic                    i_mem_write,
  input  logic [2:0]              i_funct3,
  input  logic [rv_pkg::XLEN-1:0] i_addr,
  input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_pkg::XLEN-1:0] i_mem_rdata,
  input  rv_pkg::wb_sel_e         i_wb_sel,
  input  logic [rv_pkg::XLEN-1:0] i_alu_result,
  input  logic [rv_pkg::XLEN-1:0] i_pc4,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  output logic [rv_pkg::XLEN-1:0] o_mem_addr,
  output logic [rv_pkg::XLEN-1:0] o_mem_wdata,
  output logic [3:0]              o_mem_be,
  output logic                    o_mem_we,
  output logic                    o_mem_re,
  output logic [rv_pkg::XLEN-1:0] o_wb_data
);
  import rv_pkg::*;

  logic [3:0]      be_lanes;
  logic [XLEN-1:0] byte_sh, half_sh;
  logic [XLEN-1:0] load_data;

  assign o_mem_addr = i_addr;
  assign o_mem_we   = i_mem_write && !i_reset; // Strobes held low in reset
  assign o_mem_re   = i_mem_read && !i_reset;
  assign o_mem_be   = o_mem_we ? be_lanes : 4'b0000;

  // Halfword store lanes ignore addr bit 0
  always_comb begin
    case (i_funct3[1:0])
      2'b00: begin
        o_mem_wdata = {4{i_rs2_data[7:0]}};
        be_lanes    = 4'b0001 << i_addr[1:0];
      end
      2'b01: begin
        o_mem_wdata = {2{i_rs2_data[15:0]}};
        be_lanes    = i_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        o_mem_wdata = i_rs2_data;
        be_lanes    = 4'b1111;
      end
    endcase
  end

  assign byte_sh = i_mem_rdata >> {i_addr[1:0], 3'b000};
  assign half_sh = i_mem_rdata >> {i_addr[1], 4'b0000};

  always_comb begin
    case (i_funct3)
      3'b000:  load_data = {{(XLEN-8){byte_sh[7]}}, byte_sh[7:0]};    // LB
      3'b001:  load_data = {{(XLEN-16){half_sh[15]}}, half_sh[15:0]}; // LH
      3'b100:  load_data = {{(XLEN-8){1'b0}}, byte_sh[7:0]};          // LBU
      3'b101:  load_data = {{(XLEN-16){1'b0}}, half_sh[15:0]};        // LHU
      default: load_data = i_mem_rdata;
    endcase
  end

  always_comb begin
    case (i_wb_sel)
      WB_LOAD: o_wb_data = load_data;
      WB_PC4:  o_wb_data = i_pc4;   // Link address
      WB_IMM:  o_wb_data = i_imm;   // LUI
      default: o_wb_data = i_alu_result;
    endcase
  end

endmodule

// ==== hdl/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_branch,
  input  logic                    i_jal,
  input  logic                    i_jalr,
  input  logic [2:0]              i_funct3,
  input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  input  logic [rv_pkg::XLEN-1:0] i_alu_result,
  output logic [rv_pkg::XLEN-1:0] o_pc,
  output logic [rv_pkg::XLEN-1:0] o_pc4
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] next_pc;
  logic            eq, lt, ltu;
  logic            taken;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_funct3)
      3'b000:  taken = eq;   // BEQ
      3'b001:  taken = !eq;  // BNE
      3'b100:  taken = lt;   // BLT
      3'b101:  taken = !lt;  // BGE
      3'b110:  taken = ltu;  // BLTU
      3'b111:  taken = !ltu; // BGEU
      default: taken = 1'b0;
    endcase
  end

  assign o_pc4 = pc_q + 32'd4;

  always_comb begin
    if ((i_branch && taken) || i_jal) next_pc = pc_q + i_imm;
    else if (i_jalr)                  next_pc = {i_alu_result[XLEN-1:1], 1'b0};
    else                              next_pc = o_pc4;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) pc_q <= '0;
    else         pc_q <= next_pc;
  end

  assign o_pc = pc_q;

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic [rv_pkg::REG_AW-1:0] i_rs1,
  input  logic [rv_pkg::REG_AW-1:0] i_rs2,
  input  logic [rv_pkg::REG_AW-1:0] i_rd,
  input  logic                      i_we,
  input  logic [rv_pkg::XLEN-1:0]   i_wdata,
  output logic [rv_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]   o_rs2_data
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 reads as zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic [31:0]             i_inst,
  input  logic [rv_pkg::XLEN-1:0] i_mem_rdata,
  output logic [rv_pkg::XLEN-1:0] o_pc,
  output logic [rv_pkg::XLEN-1:0] o_mem_addr,
  output logic [rv_pkg::XLEN-1:0] o_mem_wdata,
  output logic [3:0]              o_mem_be,
  output logic                    o_mem_we,
  output logic                    o_mem_re
);
  import rv_pkg::*;

  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]   imm;
  alu_op_e           alu_op;
  logic              alu_src_imm, alu_src_pc;
  logic              reg_write;
  logic              branch, jal, jalr;
  logic              mem_read, mem_write;
  logic [2:0]        funct3;
  wb_sel_e           wb_sel;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  logic [XLEN-1:0]   alu_result;
  logic [XLEN-1:0]   pc4;
  logic [XLEN-1:0]   wb_data;

  inst_decoder decoder_i (
    .i_inst        (i_inst),
    .o_rs1         (rs1),
    .o_rs2         (rs2),
    .o_rd          (rd),
    .o_imm         (imm),
    .o_alu_op      (alu_op),
    .o_alu_src_imm (alu_src_imm),
    .o_alu_src_pc  (alu_src_pc),
    .o_reg_write   (reg_write),
    .o_branch      (branch),
    .o_jal         (jal),
    .o_jalr        (jalr),
    .o_mem_read    (mem_read),
    .o_mem_write   (mem_write),
    .o_funct3      (funct3),
    .o_wb_sel      (wb_sel)
  );

  reg_file reg_file_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (reg_write),
    .i_wdata    (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu alu_i (
    .i_op      (alu_op),
    .i_a       (rs1_data),
    .i_b       (rs2_data),
    .i_src_pc  (alu_src_pc),
    .i_src_imm (alu_src_imm),
    .i_pc      (o_pc),
    .i_imm     (imm),
    .o_result  (alu_result)
  );

  pc_unit pc_unit_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_branch     (branch),
    .i_jal        (jal),
    .i_jalr       (jalr),
    .i_funct3     (funct3),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_imm        (imm),
    .i_alu_result (alu_result),
    .o_pc         (o_pc),
    .o_pc4        (pc4)
  );

  // ALU sum doubles as the byte address
  mem_wb_unit mem_wb_i (
    .i_reset      (i_reset),
    .i_mem_read   (mem_read),
    .i_mem_write  (mem_write),
    .i_funct3     (funct3),
    .i_addr       (alu_result),
    .i_rs2_data   (rs2_data),
    .i_mem_rdata  (i_mem_rdata),
    .i_wb_sel     (wb_sel),
    .i_alu_result (alu_result),
    .i_pc4        (pc4),
    .i_imm        (imm),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .o_mem_be     (o_mem_be),
    .o_mem_we     (o_mem_we),
    .o_mem_re     (o_mem_re),
    .o_wb_data    (wb_data)
  );

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN   = 32; // Data and address width
  localparam int REG_AW = 5;  // Register address width

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD     = 5'b00000,
    OP_MISC_MEM = 5'b00011,
    OP_IMM      = 5'b00100,
    OP_AUIPC    = 5'b00101,
    OP_STORE    = 5'b01000,
    OP_REG      = 5'b01100,
    OP_LUI      = 5'b01101,
    OP_BRANCH   = 5'b11000,
    OP_JALR     = 5'b11001,
    OP_JAL      = 5'b11011,
    OP_SYSTEM   = 5'b11100
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_e;

  // Writeback source for rd
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4,
    WB_IMM
  } wb_sel_e;

endpackage

// ==== src.f ====
hdl/rv_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/mem_wb_unit.sv
hdl/rv_core.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv
